// ==== bench/tb_wb_host.sv ====
// testbench top: clock, reset, case file masters, slave model, watchdog and checker
`timescale 1ns/1ps

module tb_wb_host;

  import wbh_bus_pkg::*;
  import wbh_map_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 4;
  localparam int COLS         = 6;    // master we adr dat sel rdata
  localparam int MAX_CASES    = 64;
  localparam int CYC_PER_CASE = 200;  // watchdog budget per case
  localparam int REPEATS      = 2;    // back to back issues of each case

  logic        clk;
  logic        s_reset_n;
  wb_req_t     m_req     [NUM_MASTERS];
  wb_rsp_t     m_rsp     [NUM_MASTERS];
  wb_dat_t     exp_rdata [NUM_MASTERS];
  wb_req_t     wbs_req;
  wb_rsp_t     wbs_rsp;
  wb_dat_t     cfg_clk_ctrl1;
  int          check_cnt;
  int          error_cnt;
  logic [31:0] cases [MAX_CASES*COLS];
  int          n_cases  = 0;
  int          budget   = 0;  // watchdog time in ns
  int          seed     = 32'h43098699;
  int          slot [NUM_MASTERS];  // case index per master in a batch, -1 idle
  int          wait_cnt = 0;
  logic        slv_hit;
  wb_adr_t     slv_adr;

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  wb_host u_wb_host (
    .wbm_clk_i       (clk),
    .s_reset_n       (s_reset_n),
    .m_req_i         (m_req),
    .m_rsp_o         (m_rsp),
    .wbs_req_o       (wbs_req),
    .wbs_rsp_i       (wbs_rsp),
    .cfg_clk_ctrl1_o (cfg_clk_ctrl1)
  );

  wbh_checker u_checker (
    .wbm_clk_i       (clk),
    .s_reset_n       (s_reset_n),
    .m_req_i         (m_req),
    .m_rsp_i         (m_rsp),
    .exp_rdata_i     (exp_rdata),
    .wbs_req_i       (wbs_req),
    .cfg_clk_ctrl1_i (cfg_clk_ctrl1),
    .check_cnt_o     (check_cnt),
    .error_cnt_o     (error_cnt)
  );

  // --------------------
  // slave model
  // --------------------
  // ack two cycles into a strobe, data = adr ^ a5a50000, err on odd address
  always begin
    @(negedge clk);
    slv_hit = wbs_req.stb && !wbs_rsp.ack;
    slv_adr = wbs_req.adr;
    @(posedge clk);
    #1;
    if (!s_reset_n || !slv_hit) begin
      wbs_rsp.ack = 1'b0;
      wbs_rsp.err = 1'b0;
      wait_cnt    = 0;
    end else if (wait_cnt == 1) begin
      wbs_rsp  = '{dat: slv_adr ^ 32'hA5A5_0000, ack: 1'b1, err: slv_adr[0]};
      wait_cnt = 0;
    end else begin
      wait_cnt++;
    end
  end

  // one master transfer, held until ack, then issued again after one idle cycle
  // so the master comes back while the others of its batch still wait
  task automatic run_case(input int m, input int idx);
    int base;
    if (idx < 0) return;
    base         = idx * COLS;
    exp_rdata[m] = cases[base+5];
    for (int r = 0; r < REPEATS; r++) begin
      if (r > 0) begin
        @(posedge clk);  // idle cycle between repeats
        #1;
      end
      m_req[m] = '{cyc: 1'b1, stb: 1'b1, adr: cases[base+2], we: cases[base+1][0],
                   dat: cases[base+3], sel: cases[base+4][3:0]};
      @(negedge clk);
      while (!m_rsp[m].ack) @(negedge clk);
      @(posedge clk);
      #1;
      m_req[m] = WB_REQ_IDLE;
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int gap;
    int m;
    int nxt;
    s_reset_n = 1'b0;
    wbs_rsp   = WB_RSP_IDLE;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      m_req[k]     = WB_REQ_IDLE;
      exp_rdata[k] = '0;
    end
    for (int i = 0; i < MAX_CASES*COLS; i++) begin
      cases[i] = ~i;  // unused rows match no master index
    end
    $readmemh("bench/wbh_cases.txt", cases);
    while (n_cases < MAX_CASES && cases[n_cases*COLS] < NUM_MASTERS) n_cases++;
    budget = (n_cases * CYC_PER_CASE + RST_CYCLES) * CLK_PERIOD;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    s_reset_n = 1'b1;
    nxt = 0;
    while (nxt < n_cases) begin
      gap = 1 + $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
      #1;
      for (int k = 0; k < NUM_MASTERS; k++) slot[k] = -1;
      // rising master numbers form one batch that requests together
      m       = cases[nxt*COLS];
      slot[m] = nxt;
      nxt++;
      while (nxt < n_cases && cases[nxt*COLS] > cases[(nxt-1)*COLS]) begin
        m       = cases[nxt*COLS];
        slot[m] = nxt;
        nxt++;
      end
      fork
        run_case(0, slot[0]);
        run_case(1, slot[1]);
        run_case(2, slot[2]);
      join
    end
    repeat (RST_CYCLES) @(posedge clk);
    if (n_cases == 0) $display("no cases read from bench/wbh_cases.txt");
    $display("cases: %0d, checks: %0d, errors: %0d", n_cases, check_cnt, error_cnt);
    if (error_cnt == 0 && n_cases > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog, armed once the case count is known
  initial begin
    wait (budget > 0);
    #(budget);
    $display("timeout: cases not done within %0d cycles, errors so far: %0d",
             budget / CLK_PERIOD, error_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== bench/wbh_cases.txt ====
// columns: master we address wdata sel expected_rdata, all hex
// local regs at adr[19] = 1, remote rdata = banked adr ^ a5a50000
0 0 00080000 00000000 f 00001000
0 0 00080004 00000000 f 00000000
0 1 00080004 11223344 5 00000000
0 0 00080004 00000000 f 00220044
0 1 00080004 aabbccdd a 00000000
0 0 00080004 00000000 f aa22cc44
1 0 00080008 00000000 f 00000000
1 0 00012340 00000000 f b5a42340
2 0 00012341 00000000 f b5a42341
2 1 00080000 00002468 3 00000000
2 0 00080000 00000000 f 00002468
1 0 0007fffc 00000000 f 81cafffc
0 1 00012348 cafef00d c 00000000
0 1 00080000 ffffffff c 00000000
0 0 00080000 00000000 f 00002468
0 0 00000100 00000000 f 81cd0100
1 0 00000204 00000000 f 81cd0204
2 0 00000308 00000000 f 81cd0308
0 1 00080004 0000ff00 2 00000000
1 0 00040000 00000000 f 81c90000
2 0 00000011 00000000 f 81cd0011
0 0 00080004 00000000 f aa22ff44

// ==== bench/wbh_checker.sv ====
// testbench checker: watches the host ports and compares responses with a reference model
`timescale 1ns/1ps

module wbh_checker (
  input  logic                  wbm_clk_i,
  input  logic                  s_reset_n,
  input  wbh_bus_pkg::wb_req_t  m_req_i     [wbh_map_pkg::NUM_MASTERS],
  input  wbh_bus_pkg::wb_rsp_t  m_rsp_i     [wbh_map_pkg::NUM_MASTERS],
  input  wbh_bus_pkg::wb_dat_t  exp_rdata_i [wbh_map_pkg::NUM_MASTERS],  // from case file
  input  wbh_bus_pkg::wb_req_t  wbs_req_i,
  input  wbh_bus_pkg::wb_dat_t  cfg_clk_ctrl1_i,
  output int                    check_cnt_o,
  output int                    error_cnt_o
);

  import wbh_bus_pkg::*;
  import wbh_map_pkg::*;

  int      n_checks = 0;
  int      n_errors = 0;
  wb_dat_t bank_mdl;      // bank register, zero extended
  wb_dat_t clk_mdl;       // clk ctrl1 register
  wb_req_t wbs_seen;      // last strobed slave request
  logic    remote_seen;   // slave strobed since the last ack
  logic [NUM_MASTERS-1:0] served [NUM_MASTERS];  // [o][m] m acked while o waited
  int      n_ack;

  assign check_cnt_o = n_checks;
  assign error_cnt_o = n_errors;

  // byte lane merge, same rule as a wishbone write with sel
  function automatic wb_dat_t merge_bytes(wb_dat_t old_val, wb_dat_t wdat, wb_sel_t sel);
    wb_dat_t res;
    res = old_val;
    for (int b = 0; b < $bits(wb_sel_t); b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdat[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report(input string msg);
    n_errors++;
    $display("FAIL @%0t: %s", $time, msg);
  endtask

  // --------------------
  // one acked transfer
  // --------------------
  task automatic check_ack(input int m);
    wb_req_t req;
    logic    exp_err;
    wb_adr_t exp_adr;
    req     = m_req_i[m];
    exp_err = !req.adr[LOCAL_SEL_BIT] && req.adr[0];  // slave errs on odd address
    n_checks++;
    if (!(req.cyc && req.stb)) begin
      report($sformatf("m%0d acked with no request", m));
    end else begin
      if (!req.we && m_rsp_i[m].dat !== exp_rdata_i[m]) begin
        report($sformatf("m%0d read %h at %h, expected %h",
                         m, m_rsp_i[m].dat, req.adr, exp_rdata_i[m]));
      end
      if (m_rsp_i[m].err !== exp_err) begin
        report($sformatf("m%0d err %b at %h, expected %b", m, m_rsp_i[m].err, req.adr, exp_err));
      end
      if (req.adr[LOCAL_SEL_BIT]) begin
        if (remote_seen) begin
          report($sformatf("m%0d local access %h also reached the slave", m, req.adr));
        end
        if (req.we && req.adr[4:2] == REG_BANK_SEL) begin
          bank_mdl = merge_bytes(bank_mdl, req.dat, req.sel) & 32'h0000_ffff;  // 16 bit reg
        end
        if (req.we && req.adr[4:2] == REG_CLK_CTRL1) begin
          clk_mdl = merge_bytes(clk_mdl, req.dat, req.sel);
        end
      end else begin
        exp_adr = {bank_mdl[15:BANK_LSB], req.adr[ADR_KEEP_MSB:0]};
        if (!remote_seen) begin
          report($sformatf("m%0d remote ack with no slave strobe", m));
        end else if (wbs_seen.adr !== exp_adr) begin
          report($sformatf("slave adr %h, expected %h", wbs_seen.adr, exp_adr));
        end else if ({wbs_seen.dat, wbs_seen.we, wbs_seen.sel} !== {req.dat, req.we, req.sel}) begin
          report($sformatf("m%0d slave dat/we/sel differ from the request", m));
        end
      end
    end
    remote_seen = 1'b0;
  endtask

  // --------------------
  // mid cycle sampling
  // --------------------
  always @(negedge wbm_clk_i) begin
    n_ack = 0;
    if (!s_reset_n) begin
      bank_mdl    = wb_dat_t'(BANK_SEL_RST);
      clk_mdl     = CLK_CTRL1_RST;
      remote_seen = 1'b0;
      for (int o = 0; o < NUM_MASTERS; o++) begin
        served[o] = '0;
        if (m_rsp_i[o].ack !== 1'b0) report($sformatf("m%0d ack not low in reset", o));
      end
      if (wbs_req_i.stb !== 1'b0 || wbs_req_i.cyc !== 1'b0) begin
        report("slave stb/cyc not low in reset");
      end
    end else begin
      if (wbs_req_i.stb) begin
        wbs_seen    = wbs_req_i;  // held until ack
        remote_seen = 1'b1;
        if (wbs_req_i.cyc !== 1'b1) report("slave stb without cyc");
      end
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (m_rsp_i[m].ack) begin
          check_ack(m);
          n_ack++;
        end else if (m_rsp_i[m].err !== 1'b0) begin
          report($sformatf("m%0d err without ack", m));
        end
      end
      if (n_ack > 1) report($sformatf("%0d masters acked in one cycle", n_ack));
      // round robin fairness, nobody passed twice
      for (int o = 0; o < NUM_MASTERS; o++) begin
        if (m_rsp_i[o].ack || !(m_req_i[o].cyc && m_req_i[o].stb)) begin
          served[o] = '0;
        end else begin
          for (int m = 0; m < NUM_MASTERS; m++) begin
            if (m_rsp_i[m].ack && served[o][m]) begin
              report($sformatf("m%0d served twice while m%0d waited", m, o));
            end
            if (m_rsp_i[m].ack) served[o][m] = 1'b1;
          end
        end
      end
    end
    n_checks++;
    if (cfg_clk_ctrl1_i !== clk_mdl) begin
      report($sformatf("cfg_clk_ctrl1 %h, expected %h", cfg_clk_ctrl1_i, clk_mdl));
    end
  end

endmodule

// ==== design/wb_host.sv ====
// wishbone host top: three masters arbitrated onto local registers and one slave port
`timescale 1ns/1ps

module wb_host (
  input  logic                  wbm_clk_i,
  input  logic                  s_reset_n,
  input  wbh_bus_pkg::wb_req_t  m_req_i [wbh_map_pkg::NUM_MASTERS],  // m0 ext, m1 uart, m2 spi
  output wbh_bus_pkg::wb_rsp_t  m_rsp_o [wbh_map_pkg::NUM_MASTERS],
  output wbh_bus_pkg::wb_req_t  wbs_req_o,
  input  wbh_bus_pkg::wb_rsp_t  wbs_rsp_i,
  output wbh_bus_pkg::wb_dat_t  cfg_clk_ctrl1_o
);

  import wbh_bus_pkg::*;
  import wbh_map_pkg::*;

  grant_e                 grant;
  logic [NUM_MASTERS-1:0] qual_req;                  // per master cyc & stb
  wb_req_t                port_req [NUM_MASTERS];    // gated, at most one nonzero
  wb_rsp_t                shared_rsp;
  bank_sel_t              bank_sel;

  // local register bus
  logic     reg_cs;
  logic     reg_wr;
  reg_idx_t reg_idx;
  wb_dat_t  reg_wdata;
  wb_sel_t  reg_be;
  wb_dat_t  reg_rdata;
  logic     reg_ack;

  // --------------------
  // arbitration
  // --------------------
  wbh_arb u_arb (
    .wbm_clk_i (wbm_clk_i),
    .s_reset_n (s_reset_n),
    .req_i     (qual_req),
    .grant_o   (grant)
  );

  for (genvar g = 0; g < NUM_MASTERS; g++) begin : g_port
    wbh_port u_port (
      .is_granted_i (grant == grant_e'(g)),
      .m_req_i      (m_req_i[g]),
      .m_rsp_o      (m_rsp_o[g]),
      .qual_req_o   (qual_req[g]),
      .port_req_o   (port_req[g]),
      .shared_rsp_i (shared_rsp)
    );
  end

  // --------------------
  // request path
  // --------------------
  wbh_req_stage u_req_stage (
    .wbm_clk_i    (wbm_clk_i),
    .s_reset_n    (s_reset_n),
    .port_req_i   (port_req),
    .shared_rsp_o (shared_rsp),
    .bank_sel_i   (bank_sel),
    .reg_cs_o     (reg_cs),
    .reg_wr_o     (reg_wr),
    .reg_idx_o    (reg_idx),
    .reg_wdata_o  (reg_wdata),
    .reg_be_o     (reg_be),
    .reg_rdata_i  (reg_rdata),
    .reg_ack_i    (reg_ack),
    .wbs_req_o    (wbs_req_o),
    .wbs_rsp_i    (wbs_rsp_i)
  );

  wbh_reg u_reg (
    .wbm_clk_i       (wbm_clk_i),
    .s_reset_n       (s_reset_n),
    .reg_cs_i        (reg_cs),
    .reg_wr_i        (reg_wr),
    .reg_idx_i       (reg_idx),
    .reg_wdata_i     (reg_wdata),
    .reg_be_i        (reg_be),
    .reg_rdata_o     (reg_rdata),
    .reg_ack_o       (reg_ack),
    .bank_sel_o      (bank_sel),     // feeds the address msbs
    .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o)
  );

endmodule

// ==== design/wbh_arb.sv ====
// round robin arbiter, grant held while the owning master keeps requesting
`timescale 1ns/1ps

module wbh_arb (
  input  logic                                   wbm_clk_i,
  input  logic                                   s_reset_n,
  input  logic [wbh_map_pkg::NUM_MASTERS-1:0]    req_i,     // cyc & stb per master
  output wbh_map_pkg::grant_e                    grant_o
);

  import wbh_map_pkg::*;

  grant_e grant_q;    // current owner
  grant_e grant_nxt;

  // --------------------
  // next owner
  // --------------------
  always_comb begin
    int cand;  // candidate master index
    cand      = 0;
    grant_nxt = grant_q;  // default: keep
    if (!req_i[grant_q]) begin  // owner idle, look ahead
      // walk from the farthest to the nearest, nearest wins
      for (int k = NUM_MASTERS - 1; k >= 1; k--) begin
        cand = (int'(grant_q) + k) % NUM_MASTERS;
        if (req_i[cand]) begin
          grant_nxt = grant_e'(cand[1:0]);
        end
      end
    end
  end

  always_ff @(posedge wbm_clk_i) begin
    if (!s_reset_n) begin
      grant_q <= GNT_M0;  // m0 owns after reset
    end else begin
      grant_q <= grant_nxt;
    end
  end

  assign grant_o = grant_q;

  // the new owner still holds the request that won it the path
  a_owner_live : assert property (
    @(posedge wbm_clk_i) disable iff (!s_reset_n)
    !$stable(grant_q) |-> req_i[grant_q]
  ) else $error("grant moved to a master that is not requesting");

endmodule

// ==== design/wbh_bus_pkg.sv ====
// wishbone host bus package: data path vector types and request/response bundles
package wbh_bus_pkg;

  // --------------------
  // vector widths
  // --------------------
  localparam int ADR_W = 32;           // byte address
  localparam int DAT_W = 32;           // one bus word
  localparam int SEL_W = DAT_W / 8;    // one enable per byte

  typedef logic [ADR_W-1:0] wb_adr_t;  // bus address
  typedef logic [DAT_W-1:0] wb_dat_t;  // data word
  typedef logic [SEL_W-1:0] wb_sel_t;  // byte enables

  // --------------------
  // request bundle
  // --------------------
  // one master's view of the bus, held until ack
  typedef struct packed {
    logic    cyc;  // bus cycle in progress
    logic    stb;  // transfer strobe
    wb_adr_t adr;  // target address
    logic    we;   // 1 = write
    wb_dat_t dat;  // write data
    wb_sel_t sel;  // byte lanes
  } wb_req_t;

  // --------------------
  // response bundle
  // --------------------
  // ack/err pulse for one cycle, dat valid with ack on reads
  typedef struct packed {
    wb_dat_t dat;  // read data
    logic    ack;  // transfer done
    logic    err;  // transfer failed
  } wb_rsp_t;

  // idle values, handy for gating
  localparam wb_req_t WB_REQ_IDLE = '0;
  localparam wb_rsp_t WB_RSP_IDLE = '0;

endpackage

// ==== design/wbh_map_pkg.sv ====
// wishbone host address map: local decode, register offsets, resets and arbiter state
package wbh_map_pkg;

  import wbh_bus_pkg::*;

  // --------------------
  // masters
  // --------------------
  localparam int NUM_MASTERS = 3;  // external, uart bridge, spi bridge

  // round robin owner, also the arbiter state
  typedef enum logic [1:0] {
    GNT_M0,
    GNT_M1,
    GNT_M2
  } grant_e;

  // --------------------
  // address map
  // --------------------
  // adr[19] = 1 -> local regs, else slave port with banked msbs
  localparam int LOCAL_SEL_BIT = 19;
  localparam int ADR_KEEP_MSB  = 18;  // adr[18:0] passed straight through
  localparam int BANK_LSB      = 3;   // bank_sel[15:3] -> adr[31:19]

  typedef logic [15:0] bank_sel_t;  // bank register
  typedef logic [2:0]  reg_idx_t;   // word index, adr[4:2]

  // --------------------
  // local registers
  // --------------------
  localparam reg_idx_t REG_BANK_SEL  = 3'd0;
  localparam reg_idx_t REG_CLK_CTRL1 = 3'd1;

  // reset values
  localparam bank_sel_t BANK_SEL_RST  = 16'h1000;
  localparam wb_dat_t   CLK_CTRL1_RST = '0;

endpackage

// ==== design/wbh_port.sv ====
// per master port: qualifies the strobe and gates request and response by the grant
`timescale 1ns/1ps

module wbh_port (
  input  logic                  is_granted_i,  // this master owns the path
  input  wbh_bus_pkg::wb_req_t  m_req_i,       // from master
  output wbh_bus_pkg::wb_rsp_t  m_rsp_o,       // to master
  output logic                  qual_req_o,    // to arbiter
  output wbh_bus_pkg::wb_req_t  port_req_o,    // to request stage, zero if not owner
  input  wbh_bus_pkg::wb_rsp_t  shared_rsp_i   // registered response, all ports
);

  import wbh_bus_pkg::*;

  wb_req_t req_qual;  // master request with stb tied to cyc

  // stb alone means nothing without cyc
  assign qual_req_o = m_req_i.cyc & m_req_i.stb;

  always_comb begin
    req_qual     = m_req_i;
    req_qual.stb = qual_req_o;
  end

  // --------------------
  // grant gating
  // --------------------
  // only the owner reaches the shared OR
  assign port_req_o = is_granted_i ? req_qual : WB_REQ_IDLE;

  // others see ack/err low, data zeroed as well
  assign m_rsp_o    = is_granted_i ? shared_rsp_i : WB_RSP_IDLE;

  // an ack landing here must meet a live request of this master,
  // otherwise the grant moved under an outstanding transfer
  always_comb begin
    if (shared_rsp_i.ack && is_granted_i) begin
      a_ack_owner : assert (qual_req_o)
        else $error("ack delivered to a master with no request");
    end
  end

endmodule

// ==== design/wbh_reg.sv ====
// local register block: bank select and clock control 1, byte enabled writes
`timescale 1ns/1ps

module wbh_reg (
  input  logic                   wbm_clk_i,
  input  logic                   s_reset_n,
  input  logic                   reg_cs_i,
  input  logic                   reg_wr_i,
  input  wbh_map_pkg::reg_idx_t  reg_idx_i,
  input  wbh_bus_pkg::wb_dat_t   reg_wdata_i,
  input  wbh_bus_pkg::wb_sel_t   reg_be_i,
  output wbh_bus_pkg::wb_dat_t   reg_rdata_o,
  output logic                   reg_ack_o,
  output wbh_map_pkg::bank_sel_t bank_sel_o,
  output wbh_bus_pkg::wb_dat_t   cfg_clk_ctrl1_o
);

  import wbh_bus_pkg::*;
  import wbh_map_pkg::*;

  localparam int BANK_BYTES = $bits(bank_sel_t) / 8;

  bank_sel_t bank_sel_q;
  wb_dat_t   clk_ctrl1_q;
  logic      wr_en;

  assign wr_en = reg_cs_i & reg_wr_i;

  // --------------------
  // writes
  // --------------------
  always_ff @(posedge wbm_clk_i) begin
    if (!s_reset_n) begin
      bank_sel_q  <= BANK_SEL_RST;
      clk_ctrl1_q <= CLK_CTRL1_RST;
    end else if (wr_en) begin
      if (reg_idx_i == REG_BANK_SEL) begin
        for (int b = 0; b < BANK_BYTES; b++) begin  // upper lanes dropped
          if (reg_be_i[b]) bank_sel_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
        end
      end
      if (reg_idx_i == REG_CLK_CTRL1) begin
        for (int b = 0; b < $bits(wb_sel_t); b++) begin
          if (reg_be_i[b]) clk_ctrl1_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // --------------------
  // reads
  // --------------------
  always_comb begin
    case (reg_idx_i)
      REG_BANK_SEL:  reg_rdata_o = wb_dat_t'(bank_sel_q);  // zero extended
      REG_CLK_CTRL1: reg_rdata_o = clk_ctrl1_q;
      default:       reg_rdata_o = '0;                     // unmapped
    endcase
  end

  assign reg_ack_o       = reg_cs_i;  // single cycle access
  assign bank_sel_o      = bank_sel_q;
  assign cfg_clk_ctrl1_o = clk_ctrl1_q;

endmodule

// ==== design/wbh_req_stage.sv ====
// request stage: merges the granted request, decodes local vs slave, registers the response
`timescale 1ns/1ps

module wbh_req_stage (
  input  logic                  wbm_clk_i,
  input  logic                  s_reset_n,
  input  wbh_bus_pkg::wb_req_t  port_req_i [wbh_map_pkg::NUM_MASTERS],
  output wbh_bus_pkg::wb_rsp_t  shared_rsp_o,
  input  wbh_map_pkg::bank_sel_t bank_sel_i,
  // local register bus
  output logic                  reg_cs_o,
  output logic                  reg_wr_o,
  output wbh_map_pkg::reg_idx_t reg_idx_o,
  output wbh_bus_pkg::wb_dat_t  reg_wdata_o,
  output wbh_bus_pkg::wb_sel_t  reg_be_o,
  input  wbh_bus_pkg::wb_dat_t  reg_rdata_i,
  input  logic                  reg_ack_i,
  // slave port
  output wbh_bus_pkg::wb_req_t  wbs_req_o,
  input  wbh_bus_pkg::wb_rsp_t  wbs_rsp_i
);

  import wbh_bus_pkg::*;
  import wbh_map_pkg::*;

  wb_req_t sel_req;   // granted request
  logic    is_local;  // adr[19] decode
  logic    wb_req_q;  // registered strobe, one cycle late
  logic    ack_nxt;   // selected ack before the flop
  logic    err_nxt;
  wb_dat_t dat_nxt;
  logic    ack_q;
  logic    err_q;
  wb_dat_t dat_q;     // last read data, held

  // --------------------
  // merge
  // --------------------
  always_comb begin
    sel_req = WB_REQ_IDLE;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      sel_req = wb_req_t'(sel_req | port_req_i[k]);  // non-owners are zero
    end
  end

  assign is_local    = sel_req.adr[LOCAL_SEL_BIT];
  assign reg_cs_o    = wb_req_q & is_local;
  assign reg_wr_o    = sel_req.we;
  assign reg_idx_o   = sel_req.adr[4:2];  // word index
  assign reg_wdata_o = sel_req.dat;
  assign reg_be_o    = sel_req.sel;

  // --------------------
  // slave side
  // --------------------
  always_comb begin
    wbs_req_o     = sel_req;
    wbs_req_o.cyc = sel_req.cyc & ~is_local;
    wbs_req_o.stb = wb_req_q & ~is_local;
    // top 13 bits from bank register, rest straight through
    wbs_req_o.adr = {bank_sel_i[$bits(bank_sel_t)-1:BANK_LSB],
                     sel_req.adr[ADR_KEEP_MSB:0]};
  end

  // response source follows the chip select
  assign ack_nxt = reg_cs_o ? reg_ack_i   : wbs_rsp_i.ack;
  assign err_nxt = reg_cs_o ? 1'b0        : wbs_rsp_i.err;  // local never errs
  assign dat_nxt = reg_cs_o ? reg_rdata_i : wbs_rsp_i.dat;

  always_ff @(posedge wbm_clk_i) begin
    if (!s_reset_n) begin
      wb_req_q <= 1'b0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      wb_req_q <= sel_req.stb & ~ack_q & ~ack_nxt;  // low after any ack
      ack_q    <= ack_nxt;
      err_q    <= err_nxt;
    end
  end

  always_ff @(posedge wbm_clk_i) begin
    if (ack_nxt) begin
      dat_q <= dat_nxt;  // keep last data on the bus
    end
  end

  assign shared_rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

  // a pending slave access keeps its address, so no register hit follows it
  a_target_excl : assert property (
    @(posedge wbm_clk_i) disable iff (!s_reset_n)
    (wbs_req_o.stb && !wbs_rsp_i.ack) |-> !reg_cs_o ##1 !reg_cs_o
  ) else $error("slave strobe and register select overlap");

endmodule

// ==== files.f ====
design/wbh_bus_pkg.sv
design/wbh_map_pkg.sv
design/wbh_arb.sv
design/wbh_port.sv
design/wbh_req_stage.sv
design/wbh_reg.sv
design/wb_host.sv
bench/wbh_checker.sv
bench/tb_wb_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run of the wishbone host testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_host -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_wb_host)
sim_rc=$?
echo "$sim_out"
if [ $sim_rc -ne 0 ]; then
  echo "simulation exited with status $sim_rc"
  exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
